// ==== design/axi_lite_pkg.sv ====
package axi_lite_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

    // response codes, only the two this slave ever returns
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_t;

endpackage

// ==== design/sram_pkg.sv ====
package sram_pkg;

    // storage size in 32-bit words
    localparam int DEPTH   = 64;
    localparam int INDEX_W = $clog2(DEPTH);

    // edges from address acceptance to array access
    localparam int ACCESS_LATENCY = 2;
    localparam int LAT_W          = $clog2(ACCESS_LATENCY + 1);

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [LAT_W-1:0]   lat_cnt_t;

    // read channel FSM
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT,
        RD_RESP
    } rd_state_t;

    // write channel FSM
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_WAIT,
        WR_RESP
    } wr_state_t;

endpackage

// ==== design/sram_ctrl.sv ====
module sram_ctrl (
    input  logic clk,
    input  logic rst_n,

    // read channel handshakes
    input  logic arvalid,
    output logic arready,
    output logic rvalid,
    input  logic rready,

    // write channel handshakes
    input  logic awvalid,
    input  logic wvalid,
    output logic awready,
    output logic wready,
    output logic bvalid,
    input  logic bready,

    // datapath strobes
    output logic rd_capture,
    output logic rd_fire,
    output logic wr_capture,
    output logic wr_commit
);

    sram_pkg::rd_state_t rd_state;
    sram_pkg::wr_state_t wr_state;
    sram_pkg::lat_cnt_t  rd_cnt;
    sram_pkg::lat_cnt_t  wr_cnt;

    // low until the first edge after reset releases
    logic live;

    logic wr_accept;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            live <= 1'b0;
        end else begin
            live <= 1'b1;
        end
    end

    // read side accepts one address at a time
    assign arready    = live && (rd_state == sram_pkg::RD_IDLE);
    assign rd_capture = arvalid && arready;

    // array read happens on the edge that ends this cycle
    assign rd_fire = (rd_state == sram_pkg::RD_WAIT) &&
                     (rd_cnt == sram_pkg::lat_cnt_t'(sram_pkg::ACCESS_LATENCY - 1));

    assign rvalid = (rd_state == sram_pkg::RD_RESP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_state <= sram_pkg::RD_IDLE;
            rd_cnt   <= '0;
        end else begin
            case (rd_state)
                sram_pkg::RD_IDLE: begin
                    if (rd_capture) begin
                        rd_state <= sram_pkg::RD_WAIT;
                        rd_cnt   <= '0;
                    end
                end
                sram_pkg::RD_WAIT: begin
                    rd_cnt <= rd_cnt + 1'b1;
                    // one extra edge for the datapath to form rdata
                    if (rd_cnt == sram_pkg::lat_cnt_t'(sram_pkg::ACCESS_LATENCY)) begin
                        rd_state <= sram_pkg::RD_RESP;
                    end
                end
                sram_pkg::RD_RESP: begin
                    if (rready) begin
                        rd_state <= sram_pkg::RD_IDLE;
                    end
                end
                default: rd_state <= sram_pkg::RD_IDLE;
            endcase
        end
    end

    // AW and W are taken together so both readies follow both valids
    assign wr_accept  = live && (wr_state == sram_pkg::WR_IDLE) && awvalid && wvalid;
    assign awready    = wr_accept;
    assign wready     = wr_accept;
    assign wr_capture = wr_accept;

    assign wr_commit = (wr_state == sram_pkg::WR_WAIT) &&
                       (wr_cnt == sram_pkg::lat_cnt_t'(sram_pkg::ACCESS_LATENCY - 1));

    assign bvalid = (wr_state == sram_pkg::WR_RESP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= sram_pkg::WR_IDLE;
            wr_cnt   <= '0;
        end else begin
            case (wr_state)
                sram_pkg::WR_IDLE: begin
                    if (wr_capture) begin
                        wr_state <= sram_pkg::WR_WAIT;
                        wr_cnt   <= '0;
                    end
                end
                sram_pkg::WR_WAIT: begin
                    wr_cnt <= wr_cnt + 1'b1;
                    if (wr_cnt == sram_pkg::lat_cnt_t'(sram_pkg::ACCESS_LATENCY)) begin
                        wr_state <= sram_pkg::WR_RESP;
                    end
                end
                sram_pkg::WR_RESP: begin
                    if (bready) begin
                        wr_state <= sram_pkg::WR_IDLE;
                    end
                end
                default: wr_state <= sram_pkg::WR_IDLE;
            endcase
        end
    end

    // a pending response must not drop before the master takes it
    rvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid
    ) else $error("rvalid dropped before rready");

    bvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid
    ) else $error("bvalid dropped before bready");

    // each fire traces back to one capture in the wait window and leads on to rvalid
    rd_fire_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_fire |-> $past(rd_capture, sram_pkg::ACCESS_LATENCY) ##2 rvalid
    ) else $error("rd_fire without a matching capture or not followed by rvalid");

endmodule

// ==== design/sram_addr_path.sv ====
module sram_addr_path (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rd_capture,
    input  logic                rd_fire,
    input  logic                wr_capture,
    input  logic                wr_commit,
    input  axi_lite_pkg::addr_t araddr,
    input  axi_lite_pkg::addr_t awaddr,
    input  axi_lite_pkg::data_t wdata,
    input  axi_lite_pkg::strb_t wstrb,
    output sram_pkg::index_t    rd_index,
    output sram_pkg::index_t    wr_index,
    output axi_lite_pkg::data_t wr_data,
    output axi_lite_pkg::strb_t wr_strb,
    output logic                wr_en,
    input  axi_lite_pkg::data_t rd_word,
    output axi_lite_pkg::data_t rdata,
    output axi_lite_pkg::resp_t rresp,
    output axi_lite_pkg::resp_t bresp
);

    logic rd_in_range;
    logic wr_in_range;
    logic rd_fire_q;

    // byte offset bits are dropped before the range check
    function automatic logic in_range(input axi_lite_pkg::addr_t addr);
        return (addr >> 2) < axi_lite_pkg::addr_t'(sram_pkg::DEPTH);
    endfunction

    always_ff @(posedge clk) begin
        if (rd_capture) begin
            rd_index    <= araddr[2 +: sram_pkg::INDEX_W];
            rd_in_range <= in_range(araddr);
        end
        if (wr_capture) begin
            wr_index    <= awaddr[2 +: sram_pkg::INDEX_W];
            wr_in_range <= in_range(awaddr);
            wr_data     <= wdata;
            wr_strb     <= wstrb;
        end
        // array word is valid one edge after the fire
        if (rd_fire_q) begin
            rdata <= rd_in_range ? rd_word : '0;
            rresp <= rd_in_range ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_SLVERR;
        end
        if (wr_commit) begin
            bresp <= wr_in_range ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_fire_q <= 1'b0;
        end else begin
            rd_fire_q <= rd_fire;
        end
    end

    // out-of-range writes never reach the array
    assign wr_en = wr_commit && wr_in_range;

endmodule

// ==== design/sram_array.sv ====
module sram_array (
    input  logic                clk,
    input  logic                rd_en,
    input  sram_pkg::index_t    rd_index,
    output axi_lite_pkg::data_t rd_word,
    input  logic                wr_en,
    input  sram_pkg::index_t    wr_index,
    input  axi_lite_pkg::data_t wr_data,
    input  axi_lite_pkg::strb_t wr_strb
);

    axi_lite_pkg::data_t mem [sram_pkg::DEPTH];

    // byte-lane write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int lane = 0; lane < axi_lite_pkg::STRB_W; lane++) begin
                if (wr_strb[lane]) begin
                    mem[wr_index][8*lane +: 8] <= wr_data[8*lane +: 8];
                end
            end
        end
    end

    // registered read, sees the old word on a same-edge write
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_index];
        end
    end

    // once reset has made wr_en known it must stay known
    wr_en_known: assert property (
        @(posedge clk)
        !$isunknown($past(wr_en)) |-> !$isunknown(wr_en)
    ) else $error("wr_en went unknown after reset");

endmodule

// ==== design/axi_lite_sram.sv ====
module axi_lite_sram (
    input  logic                clk,
    input  logic                rst_n,

    // read address
    input  axi_lite_pkg::addr_t araddr,
    input  logic                arvalid,
    output logic                arready,

    // read data
    output axi_lite_pkg::data_t rdata,
    output axi_lite_pkg::resp_t rresp,
    output logic                rvalid,
    input  logic                rready,

    // write address
    input  axi_lite_pkg::addr_t awaddr,
    input  logic                awvalid,
    output logic                awready,

    // write data
    input  axi_lite_pkg::data_t wdata,
    input  axi_lite_pkg::strb_t wstrb,
    input  logic                wvalid,
    output logic                wready,

    // write response
    output axi_lite_pkg::resp_t bresp,
    output logic                bvalid,
    input  logic                bready
);

    logic rd_capture;
    logic rd_fire;
    logic wr_capture;
    logic wr_commit;
    logic wr_en;

    sram_pkg::index_t    rd_index;
    sram_pkg::index_t    wr_index;
    axi_lite_pkg::data_t wr_data;
    axi_lite_pkg::strb_t wr_strb;
    axi_lite_pkg::data_t rd_word;

    sram_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .arvalid    (arvalid),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .awvalid    (awvalid),
        .wvalid     (wvalid),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready),
        .rd_capture (rd_capture),
        .rd_fire    (rd_fire),
        .wr_capture (wr_capture),
        .wr_commit  (wr_commit)
    );

    sram_addr_path u_addr_path (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_capture (rd_capture),
        .rd_fire    (rd_fire),
        .wr_capture (wr_capture),
        .wr_commit  (wr_commit),
        .araddr     (araddr),
        .awaddr     (awaddr),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .rd_index   (rd_index),
        .wr_index   (wr_index),
        .wr_data    (wr_data),
        .wr_strb    (wr_strb),
        .wr_en      (wr_en),
        .rd_word    (rd_word),
        .rdata      (rdata),
        .rresp      (rresp),
        .bresp      (bresp)
    );

    // array read is driven straight from the fire strobe
    sram_array u_array (
        .clk      (clk),
        .rd_en    (rd_fire),
        .rd_index (rd_index),
        .rd_word  (rd_word),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb)
    );

endmodule

// ==== tb/tb_axi_lite_sram.sv ====
module tb_axi_lite_sram;

    localparam int    TIMEOUT_CYCLES = 50;
    localparam string STIM_FILE      = "tb/sram_stim.txt";

    // selectors for the handshake waits
    localparam int SIG_ARREADY = 0;
    localparam int SIG_AW_W    = 1;
    localparam int SIG_RVALID  = 2;
    localparam int SIG_BVALID  = 3;

    logic                clk = 1'b0;
    logic                rst_n;
    axi_lite_pkg::addr_t araddr;
    logic                arvalid;
    logic                arready;
    axi_lite_pkg::data_t rdata;
    axi_lite_pkg::resp_t rresp;
    logic                rvalid;
    logic                rready;
    axi_lite_pkg::addr_t awaddr;
    logic                awvalid;
    logic                awready;
    axi_lite_pkg::data_t wdata;
    axi_lite_pkg::strb_t wstrb;
    logic                wvalid;
    logic                wready;
    axi_lite_pkg::resp_t bresp;
    logic                bvalid;
    logic                bready;

    int error_count  = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    bit timed_out    = 1'b0;

    axi_lite_sram UUT (.*);

    always #10 clk = ~clk;

    function automatic logic signal_level(input int sel);
        case (sel)
            SIG_ARREADY: return arready;
            SIG_AW_W:    return awready && wready;
            SIG_RVALID:  return rvalid;
            default:     return bvalid;
        endcase
    endfunction

    // sampled on the falling edge away from the DUT's own updates
    task automatic wait_signal(input int sel, input string what, input string name,
                               output bit ok);
        int cnt;
        ok  = 1'b0;
        cnt = 0;
        while (!ok && cnt < TIMEOUT_CYCLES) begin
            @(negedge clk);
            ok = (signal_level(sel) === 1'b1);
            cnt++;
        end
        if (!ok) begin
            $display("timeout: %s did not rise within %0d cycles in test %s",
                     what, TIMEOUT_CYCLES, name);
            error_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_data(input string name, input axi_lite_pkg::data_t expected,
                              input axi_lite_pkg::data_t actual);
        if (actual !== expected) begin
            $display("FAIL %s data expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_resp(input string name, input axi_lite_pkg::resp_t expected,
                              input axi_lite_pkg::resp_t actual);
        if (actual !== expected) begin
            $display("FAIL %s resp expected %b actual %b", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (error_count == errs_before) begin
            $display("test %-20s passed", name);
        end else begin
            tests_failed++;
            $display("test %-20s failed", name);
        end
    endtask

    // random stall with valid watched before ready rises for one transfer
    task automatic hold_response(input bit is_read, input string name);
        int hold;
        int sel;
        hold = $urandom % 6;
        sel  = is_read ? SIG_RVALID : SIG_BVALID;
        repeat (hold) begin
            @(negedge clk);
            if (signal_level(sel) !== 1'b1) begin
                $display("valid dropped while ready was held low in test %s", name);
                error_count++;
            end
        end
        @(posedge clk);
        #1;
        if (is_read) rready = 1'b1;
        else bready = 1'b1;
        @(negedge clk);
        if (signal_level(sel) !== 1'b1) begin
            $display("valid was low at the response transfer in test %s", name);
            error_count++;
        end
    endtask

    task automatic start_write(input string name, input axi_lite_pkg::addr_t addr,
                               input axi_lite_pkg::data_t data,
                               input axi_lite_pkg::strb_t strb, output bit ok);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        wait_signal(SIG_AW_W, "awready and wready", name, ok);
        if (!ok) return;
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        wait_signal(SIG_BVALID, "bvalid", name, ok);
    endtask

    task automatic finish_write(input string name, input axi_lite_pkg::resp_t exp_resp);
        hold_response(1'b0, name);
        check_resp(name, exp_resp, bresp);
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic do_read(input string name, input axi_lite_pkg::addr_t addr,
                           input axi_lite_pkg::data_t exp_data,
                           input axi_lite_pkg::resp_t exp_resp);
        bit ok;
        araddr  = addr;
        arvalid = 1'b1;
        wait_signal(SIG_ARREADY, "arready", name, ok);
        if (!ok) return;
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        wait_signal(SIG_RVALID, "rvalid", name, ok);
        if (!ok) return;
        hold_response(1'b1, name);
        check_data(name, exp_data, rdata);
        check_resp(name, exp_resp, rresp);
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    initial begin
        int                  fd;
        int                  n;
        int                  errs_before;
        bit                  ok;
        bit                  pending;
        string               line;
        string               op;
        string               name;
        string               pend_name;
        axi_lite_pkg::addr_t addr;
        axi_lite_pkg::data_t data;
        axi_lite_pkg::strb_t strb;
        axi_lite_pkg::data_t exp_data;
        logic [1:0]          exp_code;
        axi_lite_pkg::resp_t pend_resp;

        void'($urandom(64489));
        rst_n   = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        pending = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // handshake outputs stay low until the first edge after reset
        errs_before = error_count;
        if (rvalid !== 1'b0 || bvalid !== 1'b0 || arready !== 1'b0 || awready !== 1'b0) begin
            $display("a valid or ready output was high right after reset");
            error_count++;
        end
        wait_signal(SIG_ARREADY, "arready", "reset", ok);
        report_test("reset", errs_before);
        @(posedge clk);
        #1;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open stimulus file %s", STIM_FILE);
            error_count++;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %s %h %h %h %h %h",
                            op, name, addr, data, strb, exp_data, exp_code);
                if (n > 0 && line.getc(0) != "#") begin
                    errs_before = error_count;
                    if (n != 7) begin
                        $display("malformed stimulus line: %s", line);
                        error_count++;
                    end else if (op == "W") begin
                        start_write(name, addr, data, strb, ok);
                        if (ok) finish_write(name, axi_lite_pkg::resp_t'(exp_code));
                    end else if (op == "P") begin
                        // response stays pending across the next line
                        start_write(name, addr, data, strb, ok);
                        pending   = ok;
                        pend_name = name;
                        pend_resp = axi_lite_pkg::resp_t'(exp_code);
                        @(posedge clk);
                        #1;
                    end else begin
                        do_read(name, addr, exp_data, axi_lite_pkg::resp_t'(exp_code));
                    end
                    if (op != "P") begin
                        report_test(name, errs_before);
                        if (pending && !timed_out) begin
                            errs_before = error_count;
                            finish_write(pend_name, pend_resp);
                            report_test(pend_name, errs_before);
                            pending = 1'b0;
                        end
                    end
                end
            end
            $fclose(fd);
        end

        $display("summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== tb/sram_stim.txt ====
# columns: op name addr wdata wstrb exp_rdata exp_resp, all hex, resp 0 OKAY and 2 SLVERR
# op W write, R read, P write whose response waits on bready through the next line
W wr_full_w0        00000000 11223344 f 00000000 0
R rd_full_w0        00000000 00000000 0 11223344 0
W wr_full_w1        00000004 a5a5a5a5 f 00000000 0
R rd_full_w1        00000004 00000000 0 a5a5a5a5 0
W wr_byte0_w1       00000004 000000ff 1 00000000 0
R rd_byte0_w1       00000004 00000000 0 a5a5a5ff 0
W wr_upper_w1       00000004 12345678 c 00000000 0
R rd_upper_w1       00000004 00000000 0 1234a5ff 0
W wr_full_w2        00000008 00000000 f 00000000 0
W wr_mid_w2         00000008 cafef00d 6 00000000 0
R rd_mid_w2         00000008 00000000 0 00fef000 0
R rd_unaligned_w1   00000006 00000000 0 1234a5ff 0
W wr_last_w63       000000fc 0badf00d f 00000000 0
R rd_last_w63       000000fc 00000000 0 0badf00d 0
W wr_oob_w64        00000100 deadbeef f 00000000 2
R rd_oob_w64        00000100 00000000 0 00000000 2
W wr_oob_top        fffffffc 87654321 f 00000000 2
R rd_oob_top        fffffffc 00000000 0 00000000 2
R rd_w0_after_oob   00000000 00000000 0 11223344 0
R rd_w63_after_oob  000000fc 00000000 0 0badf00d 0
P wr_pend_w3        0000000c 55aa55aa f 00000000 0
R rd_w0_during_wr   00000000 00000000 0 11223344 0
R rd_w3_after_wr    0000000c 00000000 0 55aa55aa 0
P wr_pend_w5        00000014 0f0f0f0f f 00000000 0
R rd_w2_during_wr   00000008 00000000 0 00fef000 0
R rd_w5_after_wr    00000014 00000000 0 0f0f0f0f 0
W wr_byte3_w5       00000014 a0000000 8 00000000 0
R rd_byte3_w5       00000014 00000000 0 a00f0f0f 0

// ==== verilog.f ====
design/axi_lite_pkg.sv
design/sram_pkg.sv
design/sram_ctrl.sv
design/sram_addr_path.sv
design/sram_array.sv
design/axi_lite_sram.sv
tb/tb_axi_lite_sram.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_axi_lite_sram
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
